// File: hw/timing_pkg.sv
`default_nettype none

package timing_pkg;

	// one word is eight rf buckets.
	localparam int WORD_BUCKETS = 8;
	localparam int PHASE_BITS = 3;

	// shortened revolution so a simulation covers many turns.
	localparam int REVO_PERIOD_WORDS = 20;
	localparam int WORD_COUNT_BITS = 5;

	// the line arrives one cycle late, so its high half spans phases 1 to 4
	// and its low half spans phases 5 to 0.
	// each sample sits in the middle of one half.
	localparam logic [PHASE_BITS-1:0] SAMPLE_HIGH_PHASE = 3'd3;
	localparam logic [PHASE_BITS-1:0] SAMPLE_LOW_PHASE = 3'd7;

endpackage

`default_nettype wire

// File: hw/frame_pkg.sv
`default_nettype none

package frame_pkg;

	// width of one calibration word.
	localparam int CAL_BITS = 8;

	// ordinary words.
	localparam logic [CAL_BITS-1:0] CAL_PATTERN = 8'b1010_1100;

	// revolution word, the complement, so the far end can find the turn.
	localparam logic [CAL_BITS-1:0] CAL_REVO_PATTERN = 8'b0101_0011;

	// revolutions seen by the decoder.
	localparam int REVO_COUNT_BITS = 16;

endpackage

`default_nettype wire

// File: hw/revo_timing_if.sv
`timescale 1ns/1ps
`default_nettype none

interface revo_timing_if import timing_pkg::*; ();

	// bucket index inside the current word.
	logic [PHASE_BITS-1:0] word_phase;
	// high for the first half of the word.
	logic word_clock;
	// one cycle at phase 0.
	logic word_start;
	// held for the whole revolution word.
	logic revo_word;

	modport divider (
		output word_phase,
		output word_clock,
		output word_start
	);

	modport generator (
		input word_start,
		output revo_word
	);

	modport consumer (
		input word_phase,
		input word_clock,
		input word_start,
		input revo_word
	);

endinterface

`default_nettype wire

// File: hw/word_clock_divider.sv
`timescale 1ns/1ps
`default_nettype none

module word_clock_divider import timing_pkg::*; (
	input wire clock,
	input wire reset,
	revo_timing_if.divider timing
);

	logic [PHASE_BITS-1:0] phase;

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= '0;
		end else if (phase == PHASE_BITS'(WORD_BUCKETS - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	assign timing.word_phase = phase;

	// first half of the word high, second half low.
	assign timing.word_clock = (phase < PHASE_BITS'(WORD_BUCKETS / 2));

	assign timing.word_start = (phase == '0);

	// the phase must step through every bucket, never skip or stall.
	phase_steps: assert property (
		@(posedge clock) disable iff (reset)
		1'b1 |=> (phase == PHASE_BITS'($past(phase) + 1'b1))
	) else $error("word phase did not advance by one");

endmodule

`default_nettype wire

// File: hw/revo_generator.sv
`timescale 1ns/1ps
`default_nettype none

module revo_generator import timing_pkg::*; (
	input wire clock,
	input wire reset,
	input wire revo_enable,
	revo_timing_if.generator timing
);

	// index of the word starting at the next word_start.
	logic [WORD_COUNT_BITS-1:0] word_count;
	logic revo_held;
	logic revo_next;

	// marker decision for the word that starts in this cycle.
	assign revo_next = revo_enable && (word_count == '0);

	// the new value shows at phase 0 itself, then is held for the word.
	assign timing.revo_word = timing.word_start ? revo_next : revo_held;

	always_ff @(posedge clock) begin
		if (reset) begin
			word_count <= '0;
			revo_held <= 1'b0;
		end else if (timing.word_start) begin
			revo_held <= revo_next;
			if (word_count == WORD_COUNT_BITS'(REVO_PERIOD_WORDS - 1)) begin
				word_count <= '0;
			end else begin
				word_count <= word_count + 1'b1;
			end
		end
	end

	// revo_enable may move mid word, the marker must not.
	revo_at_boundary: assert property (
		@(posedge clock) disable iff (reset)
		$changed(timing.revo_word) |-> timing.word_start
	) else $error("revo_word changed inside a word");

endmodule

`default_nettype wire

// File: hw/revo_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module revo_encoder (
	input wire clock,
	input wire reset,
	revo_timing_if.consumer timing,
	output logic line_out
);

	logic code;

	// single-wire code.
	// the plain word clock most of the time, inverted for the revolution word.
	// the far end gets its clock from the edges and the marker from the
	// polarity.
	assign code = timing.word_clock ^ timing.revo_word;

	// registered so the line leaves from a flop, one cycle behind the phase.
	always_ff @(posedge clock) begin
		if (reset) begin
			line_out <= 1'b0;
		end else begin
			line_out <= code;
		end
	end

endmodule

`default_nettype wire

// File: hw/revo_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module revo_decoder import timing_pkg::*, frame_pkg::*; (
	input wire clock,
	input wire reset,
	revo_timing_if.consumer timing,
	input wire line_in,
	output logic revo_recovered,
	output logic code_error,
	output logic period_error,
	output logic locked,
	output logic [REVO_COUNT_BITS-1:0] revo_count
);

	logic line_bit;
	logic sample_high;
	logic code_ok;
	logic marker;
	logic spacing_ok;
	logic [WORD_COUNT_BITS-1:0] words_since;
	logic [WORD_COUNT_BITS-1:0] words_bumped;
	logic seen_marker;
	logic one_good;

	// xor with the local word clock gives the marker level in both halves.
	assign line_bit = line_in ^ timing.word_clock;
	assign code_ok = (line_bit == sample_high);
	assign marker = code_ok && line_bit;
	assign spacing_ok = (words_since == WORD_COUNT_BITS'(REVO_PERIOD_WORDS - 1));
	assign words_bumped = (words_since == '1) ? words_since : words_since + 1'b1;

	// decisions are taken at the phase-7 sample.
	// the pulses show in the next cycle.
	always_ff @(posedge clock) begin
		if (reset) begin
			sample_high <= 1'b0;
			words_since <= '0;
			seen_marker <= 1'b0;
			one_good <= 1'b0;
			locked <= 1'b0;
			revo_count <= '0;
			revo_recovered <= 1'b0;
			code_error <= 1'b0;
			period_error <= 1'b0;
		end else begin
			revo_recovered <= 1'b0;
			code_error <= 1'b0;
			period_error <= 1'b0;
			if (timing.word_phase == SAMPLE_HIGH_PHASE) begin
				sample_high <= line_bit;
			end
			if (timing.word_phase == SAMPLE_LOW_PHASE) begin
				if (!code_ok) begin
					code_error <= 1'b1;
					locked <= 1'b0;
					one_good <= 1'b0;
					words_since <= words_bumped;
				end else if (marker) begin
					revo_recovered <= 1'b1;
					revo_count <= revo_count + 1'b1;
					words_since <= '0;
					seen_marker <= 1'b1;
					if (seen_marker && spacing_ok) begin
						locked <= locked | one_good;
						one_good <= 1'b1;
					end else if (seen_marker) begin
						period_error <= 1'b1;
						locked <= 1'b0;
						one_good <= 1'b0;
					end
				end else begin
					words_since <= words_bumped;
					// marker was due in this word and did not come.
					if (locked && spacing_ok) begin
						period_error <= 1'b1;
						locked <= 1'b0;
						one_good <= 1'b0;
					end
				end
			end
		end
	end

	one_marker_per_word: assert property (
		@(posedge clock) disable iff (reset)
		revo_recovered |=> !revo_recovered
	) else $error("revo_recovered held for two cycles");

endmodule

`default_nettype wire

// File: hw/calibration_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module calibration_serializer import frame_pkg::*; (
	input wire clock,
	input wire reset,
	input wire cal_enable,
	revo_timing_if.consumer timing,
	output logic cal_serial
);

	logic [CAL_BITS-1:0] pattern;
	logic [CAL_BITS-1:0] shift;

	// the revolution word gets its own pattern for word alignment.
	assign pattern = timing.revo_word ? CAL_REVO_PATTERN : CAL_PATTERN;

	// msb first, one bit per bucket.
	always_ff @(posedge clock) begin
		if (reset) begin
			shift <= '0;
			cal_serial <= 1'b0;
		end else if (!cal_enable) begin
			shift <= '0;
			cal_serial <= 1'b0;
		end else if (timing.word_start) begin
			cal_serial <= pattern[CAL_BITS-1];
			shift <= {pattern[CAL_BITS-2:0], 1'b0};
		end else begin
			cal_serial <= shift[CAL_BITS-1];
			shift <= {shift[CAL_BITS-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: hw/rf_revo_link.sv
`timescale 1ns/1ps
`default_nettype none

module rf_revo_link import frame_pkg::*; (
	input wire clock,
	input wire reset,
	input wire revo_enable,
	input wire cal_enable,
	input wire line_in,
	output logic word_clock_out,
	output logic line_out,
	output logic cal_serial,
	output logic revo_recovered,
	output logic code_error,
	output logic period_error,
	output logic locked,
	output logic [REVO_COUNT_BITS-1:0] revo_count
);

	revo_timing_if timing ();

	assign word_clock_out = timing.word_clock;

	// timing board side.
	word_clock_divider word_clock_divider_i (
		.clock (clock),
		.reset (reset),
		.timing (timing.divider)
	);

	revo_generator revo_generator_i (
		.clock (clock),
		.reset (reset),
		.revo_enable (revo_enable),
		.timing (timing.generator)
	);

	revo_encoder revo_encoder_i (
		.clock (clock),
		.reset (reset),
		.timing (timing.consumer),
		.line_out (line_out)
	);

	calibration_serializer calibration_serializer_i (
		.clock (clock),
		.reset (reset),
		.cal_enable (cal_enable),
		.timing (timing.consumer),
		.cal_serial (cal_serial)
	);

	// front-end side, shares the word timing.
	revo_decoder revo_decoder_i (
		.clock (clock),
		.reset (reset),
		.timing (timing.consumer),
		.line_in (line_in),
		.revo_recovered (revo_recovered),
		.code_error (code_error),
		.period_error (period_error),
		.locked (locked),
		.revo_count (revo_count)
	);

endmodule

`default_nettype wire

// File: test/rf_revo_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rf_revo_link_tb import timing_pkg::*, frame_pkg::*; ();

	localparam int REVO_CYCLES = WORD_BUCKETS * REVO_PERIOD_WORDS;
	localparam int NUM_ROWS = 7;
	// revolution inside a row that gets the corruption.
	localparam int TARGET_REV = 1;
	localparam int MODE_NONE = 0;
	localparam int MODE_CODE = 1;
	localparam int MODE_SUPPRESS = 2;

	logic clock;
	logic reset;
	logic revo_enable;
	logic cal_enable;
	logic corrupt;
	logic line_in;
	logic word_clock_out;
	logic line_out;
	logic cal_serial;
	logic revo_recovered;
	logic code_error;
	logic period_error;
	logic locked;
	logic [REVO_COUNT_BITS-1:0] revo_count;

	// one row per test case, every row starts on a revolution boundary.
	int row_revs [NUM_ROWS] = '{4, 2, 3, 3, 3, 2, 3};
	logic row_revo_en [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
	logic row_cal_en [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
	int row_mode [NUM_ROWS] = '{MODE_NONE, MODE_NONE, MODE_CODE, MODE_NONE,
		MODE_SUPPRESS, MODE_NONE, MODE_NONE};
	int row_markers [NUM_ROWS] = '{4, 2, 2, 3, 2, 0, 3};
	int row_code [NUM_ROWS] = '{0, 0, 1, 0, 0, 0, 0};
	int row_period [NUM_ROWS] = '{0, 0, 1, 0, 2, 0, 1};
	logic row_locked [NUM_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

	// reference timing, counted from the first cycle after reset.
	int tb_phase;
	int tb_word;
	logic word_revo;
	logic word_corrupt;
	logic last_code;
	logic last_cal_bit;
	int total_markers;
	int rec_seen;
	int code_seen;
	int period_seen;

	// loopback wire with a controllable flip.
	assign line_in = line_out ^ corrupt;

	rf_revo_link rf_revo_link_i (
		.clock (clock),
		.reset (reset),
		.revo_enable (revo_enable),
		.cal_enable (cal_enable),
		.line_in (line_in),
		.word_clock_out (word_clock_out),
		.line_out (line_out),
		.cal_serial (cal_serial),
		.revo_recovered (revo_recovered),
		.code_error (code_error),
		.period_error (period_error),
		.locked (locked),
		.revo_count (revo_count)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic compare_values(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic advance_cycle();
		@(posedge clock);
		#5;
		if (tb_phase == WORD_BUCKETS - 1) begin
			tb_phase = 0;
			tb_word = (tb_word == REVO_PERIOD_WORDS - 1) ? 0 : tb_word + 1;
		end else begin
			tb_phase = tb_phase + 1;
		end
	endtask

	// checks the current cycle, then drives it and moves on.
	task automatic apply_cycle(input int row, input int rev);
		logic en_now;
		logic corrupt_now;
		compare_values(int'(word_clock_out), int'(tb_phase < WORD_BUCKETS / 2), "word clock");
		compare_values(int'(line_out), int'(last_code), "line level");
		compare_values(int'(cal_serial), int'(last_cal_bit), "calibration bit");
		if (tb_phase == 0) begin
			// decisions of the word that just ended.
			compare_values(int'(revo_recovered), int'(word_revo && !word_corrupt),
				"marker pulse");
			compare_values(int'(code_error), int'(word_corrupt), "code error pulse");
		end else begin
			compare_values(int'(revo_recovered), 0, "marker pulse off phase 0");
			compare_values(int'(code_error), 0, "code error off phase 0");
			compare_values(int'(period_error), 0, "period error off phase 0");
		end
		rec_seen = rec_seen + int'(revo_recovered);
		code_seen = code_seen + int'(code_error);
		period_seen = period_seen + int'(period_error);

		en_now = row_revo_en[row];
		if (row_mode[row] == MODE_SUPPRESS && rev == TARGET_REV && tb_word == 0) begin
			en_now = 1'b0;
		end
		corrupt_now = (row_mode[row] == MODE_CODE) && (rev == TARGET_REV) &&
			(tb_word == 0) && (tb_phase == 3);
		revo_enable = en_now;
		cal_enable = row_cal_en[row];
		corrupt = corrupt_now;

		if (tb_phase == 0) begin
			word_revo = en_now && (tb_word == 0);
			word_corrupt = 1'b0;
		end
		if (corrupt_now) begin
			word_corrupt = 1'b1;
		end
		// what the registered outputs show in the next cycle.
		last_code = (tb_phase < WORD_BUCKETS / 2) ^ word_revo;
		if (!row_cal_en[row]) begin
			last_cal_bit = 1'b0;
		end else if (word_revo) begin
			last_cal_bit = CAL_REVO_PATTERN[CAL_BITS - 1 - tb_phase];
		end else begin
			last_cal_bit = CAL_PATTERN[CAL_BITS - 1 - tb_phase];
		end
		advance_cycle();
	endtask

	task automatic check_row_totals(input int row);
		compare_values(rec_seen, row_markers[row], $sformatf("row %0d markers", row));
		compare_values(code_seen, row_code[row], $sformatf("row %0d code errors", row));
		compare_values(period_seen, row_period[row], $sformatf("row %0d period errors", row));
		compare_values(int'(locked), int'(row_locked[row]), $sformatf("row %0d locked", row));
		compare_values(int'(revo_count), total_markers, $sformatf("row %0d revo count", row));
	endtask

	initial begin
		reset = 1'b1;
		revo_enable = 1'b0;
		cal_enable = 1'b0;
		corrupt = 1'b0;
		tb_phase = 0;
		tb_word = 0;
		word_revo = 1'b0;
		word_corrupt = 1'b0;
		last_code = 1'b0;
		last_cal_bit = 1'b0;
		total_markers = 0;
		repeat (3) @(posedge clock);
		#5;
		reset = 1'b0;
		for (int row = 0; row < NUM_ROWS; row++) begin
			rec_seen = 0;
			code_seen = 0;
			period_seen = 0;
			for (int i = 0; i < row_revs[row] * REVO_CYCLES; i++) begin
				apply_cycle(row, i / REVO_CYCLES);
			end
			total_markers = total_markers + row_markers[row];
			check_row_totals(row);
		end
		$display("TESTS PASSED");
		$finish;
	end

	// watchdog sized from the table.
	initial begin
		int limit;
		int watch;
		limit = 200;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit = limit + row_revs[r] * REVO_CYCLES;
		end
		watch = 0;
		while (watch <= limit) begin
			@(posedge clock);
			watch = watch + 1;
		end
		$display("timeout: run still going after %0d cycles", limit);
		$display("TESTS FAILED");
		$fatal(1, "stopped by watchdog");
	end

endmodule

`default_nettype wire

// File: rf_revo_link.f
hw/timing_pkg.sv
hw/frame_pkg.sv
hw/revo_timing_if.sv
hw/word_clock_divider.sv
hw/revo_generator.sv
hw/revo_encoder.sv
hw/revo_decoder.sv
hw/calibration_serializer.sv
hw/rf_revo_link.sv
test/rf_revo_link_tb.sv

// File: Makefile
TOP := rf_revo_link_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): rf_revo_link.f hw/*.sv test/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f rf_revo_link.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rf_revo_link.f

clean:
	rm -rf obj_dir
